/* Bender.yml */
package:
  name: cpu_core

sources:
  # packages
  - hw/cpu_isa_pkg.sv
  - hw/cpu_pipe_pkg.sv
  # interfaces
  - hw/cpu_stage_if.sv
  # RTL
  - hw/cpu_gpr.sv
  - hw/cpu_decode.sv
  - hw/cpu_execute.sv
  - hw/cpu_result.sv
  - hw/cpu_core_top.sv
  # testbench
  - target: simulation
    files:
      - tb/cpu_core_tb.sv

/* cpu_core.f */
hw/cpu_isa_pkg.sv
hw/cpu_pipe_pkg.sv
hw/cpu_stage_if.sv
hw/cpu_gpr.sv
hw/cpu_decode.sv
hw/cpu_execute.sv
hw/cpu_result.sv
hw/cpu_core_top.sv
tb/cpu_core_tb.sv

/* hw/cpu_core_top.sv */
// three stage integer core
module cpu_core_top
	import cpu_pipe_pkg::*;
	import cpu_isa_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      instr_valid,
	input  logic [INSTR_WIDTH-1:0]    instr,
	output logic                      wb_valid,
	output logic [REG_ADDR_WIDTH-1:0] wb_addr,
	output logic [DATA_WIDTH-1:0]     wb_data
);
	logic                      read0_en;
	logic [REG_ADDR_WIDTH-1:0] read0_addr;
	logic [DATA_WIDTH-1:0]     read0_data;
	logic                      read1_en;
	logic [REG_ADDR_WIDTH-1:0] read1_addr;
	logic [DATA_WIDTH-1:0]     read1_data;
	logic                      write_en;
	logic [REG_ADDR_WIDTH-1:0] write_addr;
	logic [DATA_WIDTH-1:0]     write_data;

	dec_exe_if dec_exe ();
	exe_res_if exe_res ();

	cpu_decode u_decode (
		.clk            (clk),
		.reset          (reset),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.gpr_read0_en   (read0_en),
		.gpr_read0_addr (read0_addr),
		.gpr_read1_en   (read1_en),
		.gpr_read1_addr (read1_addr),
		.dec            (dec_exe)
	);

	cpu_gpr u_gpr (
		.clk        (clk),
		.reset      (reset),
		.write_en   (write_en),
		.write_addr (write_addr),
		.write_data (write_data),
		.read0_en   (read0_en),
		.read0_addr (read0_addr),
		.read0_data (read0_data),
		.read1_en   (read1_en),
		.read1_addr (read1_addr),
		.read1_data (read1_data)
	);

	// source data arrives straight from the read ports
	cpu_execute u_execute (
		.clk     (clk),
		.reset   (reset),
		.rs_data (read0_data),
		.rt_data (read1_data),
		.dec     (dec_exe),
		.res     (exe_res),
		.fwd     (exe_res)
	);

	cpu_result u_result (
		.clk            (clk),
		.reset          (reset),
		.res            (exe_res),
		.gpr_write_en   (write_en),
		.gpr_write_addr (write_addr),
		.gpr_write_data (write_data),
		.wb_valid       (wb_valid),
		.wb_addr        (wb_addr),
		.wb_data        (wb_data)
	);

endmodule

/* hw/cpu_decode.sv */
// instruction decode stage
module cpu_decode
	import cpu_pipe_pkg::*;
	import cpu_isa_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      instr_valid,
	input  logic [INSTR_WIDTH-1:0]    instr,
	output logic                      gpr_read0_en,
	output logic [REG_ADDR_WIDTH-1:0] gpr_read0_addr,
	output logic                      gpr_read1_en,
	output logic [REG_ADDR_WIDTH-1:0] gpr_read1_addr,
	dec_exe_if.decode                 dec
);
	opcode_e                   opcode;
	funct_e                    funct;
	logic [REG_ADDR_WIDTH-1:0] rs;
	logic [REG_ADDR_WIDTH-1:0] rt;
	logic [REG_ADDR_WIDTH-1:0] rd;
	logic [REG_ADDR_WIDTH-1:0] dest;
	logic [IMM_WIDTH-1:0]      imm16;
	logic [DATA_WIDTH-1:0]     imm_ext;
	alu_op_e                   alu_op;
	logic                      use_imm;
	logic                      known;

	// ----------------------------------------------------------------------
	// field split and register read issue
	// ----------------------------------------------------------------------
	assign opcode = opcode_e'(instr[OPCODE_LSB +: OPCODE_WIDTH]);
	assign funct  = funct_e'(instr[FUNCT_WIDTH-1:0]);
	assign rs     = instr[RS_LSB +: REG_ADDR_WIDTH];
	assign rt     = instr[RT_LSB +: REG_ADDR_WIDTH];
	assign rd     = instr[RD_LSB +: REG_ADDR_WIDTH];
	assign imm16  = instr[IMM_WIDTH-1:0];

	assign gpr_read0_en   = instr_valid;
	assign gpr_read0_addr = rs;
	assign gpr_read1_en   = instr_valid;
	assign gpr_read1_addr = rt;

	// special ops write rd, immediates write rt
	assign dest = (opcode == OP_SPECIAL) ? rd : rt;

	always_comb begin
		alu_op  = ALU_ADD;
		use_imm = 1'b1;
		known   = 1'b1;
		imm_ext = {{(DATA_WIDTH-IMM_WIDTH){imm16[IMM_WIDTH-1]}}, imm16};
		case (opcode)
			OP_SPECIAL: begin
				use_imm = 1'b0;
				case (funct)
					FN_SLL:  alu_op = ALU_SLL;
					FN_SRL:  alu_op = ALU_SRL;
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_SLT:  alu_op = ALU_SLT;
					default: known = 1'b0;
				endcase
			end
			OP_ADDIU: alu_op = ALU_ADD;
			OP_SLTI:  alu_op = ALU_SLT;
			OP_ANDI: begin
				alu_op  = ALU_AND;
				imm_ext = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, imm16};
			end
			OP_ORI: begin
				alu_op  = ALU_OR;
				imm_ext = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, imm16};
			end
			OP_XORI: begin
				alu_op  = ALU_XOR;
				imm_ext = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, imm16};
			end
			OP_LUI: begin
				alu_op  = ALU_LUI;
				imm_ext = {imm16, {(DATA_WIDTH-IMM_WIDTH){1'b0}}};
			end
			default: known = 1'b0;
		endcase
	end

	// ----------------------------------------------------------------------
	// stage register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			dec.valid <= 1'b0;
			dec.wr_en <= 1'b0;
		end else begin
			dec.valid <= instr_valid;
			dec.wr_en <= instr_valid && known && (dest != '0);
		end
	end

	always_ff @(posedge clk) begin
		dec.alu_op  <= alu_op;
		dec.rs_addr <= rs;
		dec.rt_addr <= rt;
		dec.use_imm <= use_imm;
		dec.imm     <= imm_ext;
		dec.shamt   <= instr[SHAMT_LSB +: SHAMT_WIDTH];
		dec.wr_addr <= dest;
	end

endmodule

/* hw/cpu_execute.sv */
// execute stage
module cpu_execute
	import cpu_pipe_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic [DATA_WIDTH-1:0] rs_data,
	input  logic [DATA_WIDTH-1:0] rt_data,
	dec_exe_if.execute            dec,
	exe_res_if.execute            res,
	exe_res_if.fwd                fwd
);
	logic                  hit_rs;
	logic                  hit_rt;
	logic [DATA_WIDTH-1:0] op_a;
	logic [DATA_WIDTH-1:0] op_rt;
	logic [DATA_WIDTH-1:0] op_b;
	logic [DATA_WIDTH-1:0] alu_y;

	// ----------------------------------------------------------------------
	// forwarding from the instruction one ahead
	// ----------------------------------------------------------------------
	// two ahead is already covered by the register file write-through
	assign hit_rs = fwd.fwd_wr_en && (fwd.fwd_wr_addr == dec.rs_addr);
	assign hit_rt = fwd.fwd_wr_en && (fwd.fwd_wr_addr == dec.rt_addr);

	assign op_a  = hit_rs ? fwd.fwd_wr_data : rs_data;
	assign op_rt = hit_rt ? fwd.fwd_wr_data : rt_data;
	assign op_b  = dec.use_imm ? dec.imm : op_rt;

	// ----------------------------------------------------------------------
	// ALU
	// ----------------------------------------------------------------------
	always_comb begin
		case (dec.alu_op)
			ALU_ADD: alu_y = op_a + op_b;
			ALU_SUB: alu_y = op_a - op_b;
			ALU_AND: alu_y = op_a & op_b;
			ALU_OR:  alu_y = op_a | op_b;
			ALU_XOR: alu_y = op_a ^ op_b;
			ALU_SLT: alu_y = {{(DATA_WIDTH-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			// shifts take rt, never the immediate
			ALU_SLL: alu_y = op_b << dec.shamt;
			ALU_SRL: alu_y = op_b >> dec.shamt;
			// immediate already sits in the upper half
			ALU_LUI: alu_y = op_b;
			default: alu_y = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			res.valid <= 1'b0;
			res.wr_en <= 1'b0;
		end else begin
			res.valid <= dec.valid;
			res.wr_en <= dec.valid && dec.wr_en;
		end
	end

	always_ff @(posedge clk) begin
		res.wr_addr <= dec.wr_addr;
		res.wr_data <= alu_y;
	end

endmodule

/* hw/cpu_gpr.sv */
// general purpose register file
module cpu_gpr
	import cpu_pipe_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      write_en,
	input  logic [REG_ADDR_WIDTH-1:0] write_addr,
	input  logic [DATA_WIDTH-1:0]     write_data,
	input  logic                      read0_en,
	input  logic [REG_ADDR_WIDTH-1:0] read0_addr,
	output logic [DATA_WIDTH-1:0]     read0_data,
	input  logic                      read1_en,
	input  logic [REG_ADDR_WIDTH-1:0] read1_addr,
	output logic [DATA_WIDTH-1:0]     read1_data
);
	logic [DATA_WIDTH-1:0] regs [REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_addr] <= write_data;
		end
	end

	// read ports hold their data while not enabled
	// same-cycle write to the read address wins over the array
	always_ff @(posedge clk) begin
		if (reset) begin
			read0_data <= '0;
			read1_data <= '0;
		end else begin
			if (read0_en) begin
				read0_data <= (write_en && write_addr == read0_addr) ? write_data
					: regs[read0_addr];
			end
			if (read1_en) begin
				read1_data <= (write_en && write_addr == read1_addr) ? write_data
					: regs[read1_addr];
			end
		end
	end

	// r0 stays zero as long as nobody upstream writes it
	a_r0_read0_zero: assert property (@(posedge clk) disable iff (reset)
		read0_en && read0_addr == '0 |=> read0_data == '0);
	a_r0_read1_zero: assert property (@(posedge clk) disable iff (reset)
		read1_en && read1_addr == '0 |=> read1_data == '0);

endmodule

/* hw/cpu_isa_pkg.sv */
// instruction set encodings
package cpu_isa_pkg;

	// ----------------------------------------------------------------------
	// instruction format
	// ----------------------------------------------------------------------
	localparam int INSTR_WIDTH  = 32;
	localparam int OPCODE_LSB   = 26;
	localparam int OPCODE_WIDTH = 6;
	localparam int RS_LSB       = 21;
	localparam int RT_LSB       = 16;
	localparam int RD_LSB       = 11;
	localparam int SHAMT_LSB    = 6;
	localparam int FUNCT_WIDTH  = 6;
	localparam int IMM_WIDTH    = 16;

	// ----------------------------------------------------------------------
	// major opcodes and special function codes
	// ----------------------------------------------------------------------
	typedef enum logic [OPCODE_WIDTH-1:0] {
		OP_SPECIAL = 6'h00,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f
	} opcode_e;

	typedef enum logic [FUNCT_WIDTH-1:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a
	} funct_e;

endpackage

/* hw/cpu_pipe_pkg.sv */
// datapath widths and ALU operations
package cpu_pipe_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------
	localparam int DATA_WIDTH     = 32;
	localparam int REG_ADDR_WIDTH = 5;
	localparam int REG_COUNT      = 32;

	// shift amount covers one data word
	localparam int SHAMT_WIDTH    = $clog2(DATA_WIDTH);

	// ----------------------------------------------------------------------
	// ALU operations
	// ----------------------------------------------------------------------
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLT = 4'd5,
		ALU_SLL = 4'd6,
		ALU_SRL = 4'd7,
		ALU_LUI = 4'd8
	} alu_op_e;

endpackage

/* hw/cpu_result.sv */
// result and writeback stage
module cpu_result
	import cpu_pipe_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	exe_res_if.result                 res,
	output logic                      gpr_write_en,
	output logic [REG_ADDR_WIDTH-1:0] gpr_write_addr,
	output logic [DATA_WIDTH-1:0]     gpr_write_data,
	output logic                      wb_valid,
	output logic [REG_ADDR_WIDTH-1:0] wb_addr,
	output logic [DATA_WIDTH-1:0]     wb_data
);
	logic write;

	// r0 is never written, whatever comes down the pipe
	assign write = res.valid && res.wr_en && (res.wr_addr != '0);

	// register file written at the end of this cycle
	assign gpr_write_en   = write;
	assign gpr_write_addr = res.wr_addr;
	assign gpr_write_data = res.wr_data;

	// report only what actually lands in the register file
	assign wb_valid = write;
	assign wb_addr  = res.wr_addr;
	assign wb_data  = res.wr_data;

	// same write, back to execute for forwarding
	assign res.fwd_wr_en   = write;
	assign res.fwd_wr_addr = res.wr_addr;
	assign res.fwd_wr_data = res.wr_data;

	// decode must already have dropped r0 as a destination
	a_no_r0_write: assert property (@(posedge clk) disable iff (reset)
		res.valid && res.wr_en |-> res.wr_addr != '0);

endmodule

/* hw/cpu_stage_if.sv */
// pipeline stage interfaces
interface dec_exe_if
	import cpu_pipe_pkg::*;
();
	logic                      valid;
	alu_op_e                   alu_op;
	logic [REG_ADDR_WIDTH-1:0] rs_addr;
	logic [REG_ADDR_WIDTH-1:0] rt_addr;
	logic                      use_imm;
	logic [DATA_WIDTH-1:0]     imm;
	logic [SHAMT_WIDTH-1:0]    shamt;
	logic                      wr_en;
	logic [REG_ADDR_WIDTH-1:0] wr_addr;

	modport decode (output valid, alu_op, rs_addr, rt_addr, use_imm, imm, shamt,
		wr_en, wr_addr);
	modport execute (input valid, alu_op, rs_addr, rt_addr, use_imm, imm, shamt,
		wr_en, wr_addr);
endinterface

interface exe_res_if
	import cpu_pipe_pkg::*;
();
	logic                      valid;
	logic                      wr_en;
	logic [REG_ADDR_WIDTH-1:0] wr_addr;
	logic [DATA_WIDTH-1:0]     wr_data;

	// result stage write, looped back for forwarding
	logic                      fwd_wr_en;
	logic [REG_ADDR_WIDTH-1:0] fwd_wr_addr;
	logic [DATA_WIDTH-1:0]     fwd_wr_data;

	modport execute (output valid, wr_en, wr_addr, wr_data);
	modport result (input valid, wr_en, wr_addr, wr_data,
		output fwd_wr_en, fwd_wr_addr, fwd_wr_data);
	modport fwd (input fwd_wr_en, fwd_wr_addr, fwd_wr_data);
endinterface

/* tb/cpu_core_tb.sv */
// core pipeline testbench
module cpu_core_tb
	import cpu_pipe_pkg::*;
	import cpu_isa_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic [REG_ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0]     data;
		logic [31:0]               cycle;
	} wb_t;

	logic                      clk;
	logic                      reset;
	logic                      instr_valid;
	logic [INSTR_WIDTH-1:0]    instr;
	logic                      wb_valid;
	logic [REG_ADDR_WIDTH-1:0] wb_addr;
	logic [DATA_WIDTH-1:0]     wb_data;

	logic [DATA_WIDTH-1:0] model_regs [REG_COUNT];
	wb_t                   expected_q [$];
	logic [31:0]           cycle;
	int                    error_count;
	int                    check_count;
	int                    test_count;
	int                    failed_tests;
	int                    test_start_errors;

	cpu_core_top u_dut (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// ----------------------------------------------------------------------
	// checking
	// ----------------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
		end
	endtask

	// every writeback must match the oldest outstanding model result
	always @(posedge clk) begin
		wb_t head;
		if (!reset && wb_valid) begin
			if (expected_q.size() == 0) begin
				error_count++;
				$display("writeback to r%0d at cycle %0d with no instruction expecting one",
					wb_addr, cycle);
			end else begin
				head = expected_q.pop_front();
				check_value("wb_addr", wb_addr, head.addr);
				check_value("wb_data", wb_data, head.data);
				check_value("wb_cycle", cycle, head.cycle);
			end
		end
	end

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------
	function automatic void model_issue(input logic [INSTR_WIDTH-1:0] word,
		input logic [31:0] due);
		logic [OPCODE_WIDTH-1:0]   op;
		logic [FUNCT_WIDTH-1:0]    fn;
		logic [REG_ADDR_WIDTH-1:0] rs;
		logic [REG_ADDR_WIDTH-1:0] rt;
		logic [REG_ADDR_WIDTH-1:0] dest;
		logic [4:0]                sh;
		logic [DATA_WIDTH-1:0]     a;
		logic [DATA_WIDTH-1:0]     b;
		logic [DATA_WIDTH-1:0]     sext;
		logic [DATA_WIDTH-1:0]     zext;
		logic [DATA_WIDTH-1:0]     y;
		logic                      writes;
		wb_t                       item;
		op = word[OPCODE_LSB +: OPCODE_WIDTH];
		fn = word[FUNCT_WIDTH-1:0];
		rs = word[RS_LSB +: REG_ADDR_WIDTH];
		rt = word[RT_LSB +: REG_ADDR_WIDTH];
		sh = word[SHAMT_LSB +: 5];
		a = model_regs[rs];
		b = model_regs[rt];
		sext = {{16{word[15]}}, word[15:0]};
		zext = {16'h0, word[15:0]};
		dest = rt;
		writes = 1'b1;
		y = '0;
		case (op)
			OP_SPECIAL: begin
				dest = word[RD_LSB +: REG_ADDR_WIDTH];
				case (fn)
					FN_SLL:  y = b << sh;
					FN_SRL:  y = b >> sh;
					FN_ADDU: y = a + b;
					FN_SUBU: y = a - b;
					FN_AND:  y = a & b;
					FN_OR:   y = a | b;
					FN_XOR:  y = a ^ b;
					FN_SLT:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: writes = 1'b0;
				endcase
			end
			OP_ADDIU: y = a + sext;
			OP_SLTI:  y = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
			OP_ANDI:  y = a & zext;
			OP_ORI:   y = a | zext;
			OP_XORI:  y = a ^ zext;
			OP_LUI:   y = {word[15:0], 16'h0};
			default:  writes = 1'b0;
		endcase
		// r0 never changes and never reports
		if (writes && dest != '0) begin
			model_regs[dest] = y;
			item.addr = dest;
			item.data = y;
			item.cycle = due;
			expected_q.push_back(item);
		end
	endfunction

	// ----------------------------------------------------------------------
	// stimulus helpers
	// ----------------------------------------------------------------------
	function automatic logic [INSTR_WIDTH-1:0] encode_r(input logic [5:0] fn,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
		input logic [4:0] sh);
		return {OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [INSTR_WIDTH-1:0] encode_i(input logic [5:0] op,
		input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [INSTR_WIDTH-1:0] random_op(input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] dest);
		logic [5:0]  fn_list [8];
		logic [5:0]  op_list [6];
		int unsigned pick;
		fn_list = '{FN_SLL, FN_SRL, FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};
		op_list = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
		pick = $urandom % 14;
		if (pick < 8) begin
			return encode_r(fn_list[pick], rs, rt, dest, 5'($urandom));
		end else begin
			return encode_i(op_list[pick - 8], rs, dest, 16'($urandom));
		end
	endfunction

	// sampled by the DUT one edge later, reported two edges after that
	task automatic drive(input logic valid, input logic [INSTR_WIDTH-1:0] word);
		@(posedge clk);
		instr_valid <= valid;
		instr       <= word;
		if (valid) begin
			model_issue(word, cycle + 3);
		end
	endtask

	task automatic drain();
		int waited;
		@(posedge clk);
		instr_valid <= 1'b0;
		waited = 0;
		while (expected_q.size() != 0 && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if (expected_q.size() != 0) begin
			error_count++;
			$display("timed out with %0d writebacks still outstanding", expected_q.size());
			expected_q.delete();
		end
		// quiet cycles so a late spurious writeback still shows up
		repeat (3) @(posedge clk);
	endtask

	task automatic report_test(input string name);
		test_count++;
		if (error_count == test_start_errors) begin
			$display("test %0d %s: ok", test_count, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: FAILED with %0d errors", test_count, name,
				error_count - test_start_errors);
		end
		test_start_errors = error_count;
	endtask

	// ----------------------------------------------------------------------
	// tests
	// ----------------------------------------------------------------------
	task automatic test_reset_reads();
		// every register is read before anything writes it, r0 lands in r31
		for (int r = REG_COUNT - 1; r >= 0; r--) begin
			drive(1'b1, encode_i(OP_ORI, 5'(r), (r == 0) ? 5'd31 : 5'(r), 16'h0));
		end
		drain();
		report_test("reset reads");
	endtask

	task automatic test_operations();
		logic [31:0] v;
		for (int r = 1; r < 16; r++) begin
			v = $urandom;
			drive(1'b1, encode_i(OP_LUI, 5'd0, 5'(r), v[31:16]));
			drive(1'b1, encode_i(OP_ORI, 5'(r), 5'(r), v[15:0]));
		end
		for (int n = 0; n < 200; n++) begin
			drive(1'b1, random_op(5'($urandom), 5'($urandom), 5'(1 + $urandom % 31)));
		end
		drain();
		report_test("alu operations");
	endtask

	task automatic test_dependencies();
		logic [4:0]  prev;
		logic [4:0]  other;
		logic [4:0]  dest;
		int unsigned gap;
		prev = 5'd1;
		for (int n = 0; n < 60; n++) begin
			// fillers stay clear of the chain registers
			gap = $urandom % 3;
			for (int g = 0; g < gap; g++) begin
				drive(1'b1, encode_i(OP_ADDIU, 5'(20 + g), 5'(28 + g), 16'($urandom)));
			end
			other = 5'(1 + $urandom % 15);
			dest = 5'(1 + $urandom % 15);
			if ($urandom % 2) begin
				drive(1'b1, random_op(prev, other, dest));
			end else begin
				drive(1'b1, random_op(other, prev, dest));
			end
			prev = dest;
		end
		drain();
		report_test("dependencies");
	endtask

	task automatic test_r0_and_unknown();
		logic [4:0]             src;
		logic [INSTR_WIDTH-1:0] word;
		for (int n = 0; n < 40; n++) begin
			src = 5'(1 + $urandom % 15);
			case ($urandom % 4)
				0: word = encode_i(OP_ADDIU, src, 5'd0, 16'($urandom));
				1: word = encode_r(FN_OR, src, src, 5'd0, 5'd0);
				2: word = {6'h3f, 26'($urandom)};
				default: word = encode_r(6'h3f, src, src, src, 5'd0);
			endcase
			drive(1'b1, word);
			drive(1'b1, encode_i(OP_ORI, 5'd0, 5'(16 + $urandom % 15), 16'h0));
		end
		drain();
		report_test("r0 and unknown codes");
	endtask

	task automatic test_gaps();
		for (int n = 0; n < 150; n++) begin
			drive(1'($urandom % 2), random_op(5'($urandom), 5'($urandom),
				5'(1 + $urandom % 31)));
		end
		drain();
		report_test("timing and gaps");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		cycle = '0;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		failed_tests = 0;
		test_start_errors = 0;
		for (int i = 0; i < REG_COUNT; i++) begin
			model_regs[i] = '0;
		end
		void'($urandom(87648));
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		test_reset_reads();
		test_operations();
		test_dependencies();
		test_r0_and_unknown();
		test_gaps();

		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			test_count, failed_tests, check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
